// File: common/fetch_pkg.sv
package fetch_pkg;

    // ----------------------------------------
    // fetch line and slot types
    // ----------------------------------------
    typedef logic [31:0]  inst_t;
    typedef logic [127:0] line_t;    // slot 0 in the low word.
    typedef logic [1:0]   slot_t;
    typedef logic [2:0]   count_t;   // 1 to 4 usable slots.
    typedef logic [4:0]   reg_idx_t;
    typedef logic [4:0]   opc_t;     // inst[6:2].

    // 2-bit saturating counter.
    typedef logic [1:0]   ctr_t;

    localparam ctr_t CTR_WEAK_NT = 2'b01;
    localparam ctr_t CTR_MAX     = 2'b11;
    localparam ctr_t CTR_MIN     = 2'b00;

    // ----------------------------------------
    // major opcodes, valid only with inst[1:0] == 11
    // ----------------------------------------
    localparam opc_t OPC_JAL    = 5'b11011;
    localparam opc_t OPC_JALR   = 5'b11001;
    localparam opc_t OPC_BRANCH = 5'b11000;

    localparam int SLOTS    = 4;
    localparam int INST_W   = 32;

    // bus side of the fetch controller.
    typedef enum logic [1:0] {
        IDLE = 2'd0,   // request this cycle.
        BUSY = 2'd1,   // bus cycle open.
        DONE = 2'd2    // bundle held for decode.
    } bus_state_t;

endpackage

// File: rtl/predecode.sv
`timescale 1ns/1ps

module predecode #(
    parameter int PC_W = 64
) (
    input  logic [PC_W-1:0]       i_pc,
    input  fetch_pkg::line_t      i_line,
    input  logic                  i_pred_taken,
    input  logic [PC_W-1:0]       i_jreg_data,
    output fetch_pkg::reg_idx_t   o_jreg_addr,
    output logic                  o_jreg_en,
    output logic [PC_W-1:0]       o_hist_pc,
    output logic                  o_taken,
    output logic [PC_W-1:0]       o_target,
    output fetch_pkg::count_t     o_count
);

    localparam int N = fetch_pkg::SLOTS;
    localparam int W = fetch_pkg::INST_W;

    fetch_pkg::inst_t   slot_inst [N];
    logic [PC_W-1:0]    slot_pc   [N];
    logic [N-1:0]       in_rng;
    logic [N-1:0]       is_jal;
    logic [N-1:0]       is_jalr;
    logic [N-1:0]       is_br;
    logic [N-1:0]       take;
    fetch_pkg::slot_t   start;
    fetch_pkg::slot_t   br_slot;
    fetch_pkg::slot_t   sel;
    fetch_pkg::inst_t   sel_inst;
    logic [PC_W-1:0]    j_imm;
    logic [PC_W-1:0]    b_imm;
    logic [PC_W-1:0]    i_imm;
    logic [PC_W-1:0]    jalr_sum;

    assign start = i_pc[3:2];

    // ----------------------------------------
    // per-slot classify
    // ----------------------------------------
    always_comb begin
        for (int k = 0; k < N; k++) begin
            slot_inst[k] = i_line[k*W +: W];
            slot_pc[k]   = {i_pc[PC_W-1:4], fetch_pkg::slot_t'(k), 2'b00};
            in_rng[k]    = fetch_pkg::slot_t'(k) >= start;
            is_jal[k]    = (slot_inst[k][1:0] == 2'b11) &&
                           (slot_inst[k][6:2] == fetch_pkg::OPC_JAL);
            is_jalr[k]   = (slot_inst[k][1:0] == 2'b11) &&
                           (slot_inst[k][6:2] == fetch_pkg::OPC_JALR);
            is_br[k]     = (slot_inst[k][1:0] == 2'b11) &&
                           (slot_inst[k][6:2] == fetch_pkg::OPC_BRANCH);
        end
    end

    // first branch in range gets the history lookup.
    always_comb begin
        br_slot = '0;
        for (int k = N - 1; k >= 0; k--) begin
            if (in_rng[k] && is_br[k]) begin
                br_slot = fetch_pkg::slot_t'(k);
            end
        end
    end

    assign o_hist_pc = slot_pc[br_slot];

    always_comb begin
        for (int k = 0; k < N; k++) begin
            take[k] = in_rng[k] && (is_jal[k] || is_jalr[k] ||
                      (is_br[k] && br_slot == fetch_pkg::slot_t'(k) && i_pred_taken));
        end
    end

    // lowest taken slot wins.
    always_comb begin
        sel = '0;
        for (int k = N - 1; k >= 0; k--) begin
            if (take[k]) sel = fetch_pkg::slot_t'(k);
        end
    end

    assign o_taken  = |take;
    assign sel_inst = slot_inst[sel];

    // ----------------------------------------
    // immediates and target
    // ----------------------------------------
    assign j_imm = {{(PC_W-20){sel_inst[31]}}, sel_inst[19:12], sel_inst[20],
                    sel_inst[30:21], 1'b0};
    assign b_imm = {{(PC_W-12){sel_inst[31]}}, sel_inst[7], sel_inst[30:25],
                    sel_inst[11:8], 1'b0};
    assign i_imm = {{(PC_W-12){sel_inst[31]}}, sel_inst[31:20]};

    assign jalr_sum = i_jreg_data + i_imm;

    always_comb begin
        if (is_jalr[sel])     o_target = {jalr_sum[PC_W-1:1], 1'b0};
        else if (is_jal[sel]) o_target = slot_pc[sel] + j_imm;
        else                  o_target = slot_pc[sel] + b_imm;
    end

    assign o_jreg_addr = sel_inst[19:15];        // rs1.
    assign o_jreg_en   = o_taken && is_jalr[sel];

    // start slot through taken slot, else through slot 3.
    assign o_count = o_taken ? ({1'b0, sel} - {1'b0, start} + 3'd1)
                             : (3'd4 - {1'b0, start});

endmodule

// File: rtl/branch_hist.sv
`timescale 1ns/1ps

module branch_hist #(
    parameter int PC_W       = 64,
    parameter int HIST_IDX_W = 4
) (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic [PC_W-1:0]   i_lookup_pc,
    input  logic              i_bru_valid,
    input  logic [PC_W-1:0]   i_bru_pc,
    input  logic              i_bru_taken,
    output logic              o_pred_taken
);

    localparam int ENTRIES = 2 ** HIST_IDX_W;

    fetch_pkg::ctr_t         table_q [ENTRIES];
    logic                    upd_vld_q;
    logic                    upd_taken_q;
    logic [HIST_IDX_W-1:0]   upd_idx_q;
    logic [HIST_IDX_W-1:0]   lk_idx;

    assign lk_idx       = i_lookup_pc[HIST_IDX_W+1:2];
    assign o_pred_taken = table_q[lk_idx][1];  // upper bit.

    // resolve is staged one cycle before the write.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            upd_vld_q <= 1'b0;
        end else begin
            upd_vld_q <= i_bru_valid;
        end
    end

    always_ff @(posedge clk) begin
        upd_idx_q   <= i_bru_pc[HIST_IDX_W+1:2];
        upd_taken_q <= i_bru_taken;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < ENTRIES; i++) table_q[i] <= fetch_pkg::CTR_WEAK_NT;
        end else if (upd_vld_q) begin
            if (upd_taken_q && table_q[upd_idx_q] != fetch_pkg::CTR_MAX)
                table_q[upd_idx_q] <= table_q[upd_idx_q] + 2'd1;
            else if (!upd_taken_q && table_q[upd_idx_q] != fetch_pkg::CTR_MIN)
                table_q[upd_idx_q] <= table_q[upd_idx_q] - 2'd1;
        end
    end

endmodule

// File: rtl/wb_fetch_master.sv
`timescale 1ns/1ps

module wb_fetch_master #(
    parameter int PC_W = 64
) (
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_req,
    input  logic [PC_W-1:0]    i_req_adr,
    input  fetch_pkg::line_t   i_wb_dat,
    input  logic               i_wb_ack,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output logic [PC_W-1:0]    o_wb_adr,
    output logic               o_line_strobe,
    output fetch_pkg::line_t   o_line
);

    logic               cyc_q;
    logic               strobe_q;
    logic [PC_W-1:0]    adr_q;
    fetch_pkg::line_t   line_q;
    logic               start;
    logic               finish;

    assign start  = i_req && !cyc_q;
    assign finish = cyc_q && i_wb_ack;

    // ----------------------------------------
    // classic single read
    // ----------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cyc_q    <= 1'b0;
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= finish;          // one pulse after ack.
            if (finish) cyc_q <= 1'b0;
            else if (start) cyc_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) adr_q <= {i_req_adr[PC_W-1:4], 4'b0000};
        if (finish) line_q <= i_wb_dat;
    end

    // cyc and stb move as one.
    assign o_wb_cyc      = cyc_q;
    assign o_wb_stb      = cyc_q;
    assign o_wb_adr      = adr_q;
    assign o_line_strobe = strobe_q;
    assign o_line        = line_q;

endmodule

// File: pc_ctrl/pc_ctrl.sv
`timescale 1ns/1ps

module pc_ctrl #(
    parameter int              PC_W     = 64,
    parameter logic [PC_W-1:0] RESET_PC = 'h1000
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_line_strobe,
    input  fetch_pkg::line_t      i_line,
    input  logic                  i_taken,
    input  logic [PC_W-1:0]       i_target,
    input  fetch_pkg::count_t     i_count,
    input  logic                  i_fetch_ready,
    input  logic                  i_dec_redirect,
    input  logic [PC_W-1:0]       i_dec_pc,
    input  logic                  i_trap_redirect,
    input  logic [PC_W-1:0]       i_trap_pc,
    output logic                  o_req,
    output logic [PC_W-1:0]       o_req_adr,
    output logic [PC_W-1:0]       o_pc,
    output logic                  o_fetch_valid,
    output logic [PC_W-1:0]       o_fetch_pc,
    output fetch_pkg::line_t      o_fetch_line,
    output fetch_pkg::count_t     o_fetch_count
);

    fetch_pkg::bus_state_t state_q;
    logic [PC_W-1:0]       pc_q;
    logic                  pend_vld_q;
    logic                  pend_trap_q;
    logic [PC_W-1:0]       pend_pc_q;
    logic [PC_W-1:0]       fetch_pc_q;
    fetch_pkg::line_t      line_q;
    logic                  redir_now;
    logic                  redir_any;
    logic [PC_W-1:0]       seq_pc;
    logic [PC_W-1:0]       next_pc;

    assign redir_now = i_trap_redirect | i_dec_redirect;
    assign redir_any = pend_vld_q | redir_now;
    assign seq_pc    = {pc_q[PC_W-1:4] + 1'b1, 4'b0000}; // next aligned line.

    // ----------------------------------------
    // next pc priority
    // ----------------------------------------
    always_comb begin
        if (pend_vld_q)           next_pc = pend_pc_q;  // trap already beats dec here.
        else if (i_trap_redirect) next_pc = i_trap_pc;
        else if (i_dec_redirect)  next_pc = i_dec_pc;
        else if (i_taken)         next_pc = i_target;
        else                      next_pc = seq_pc;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q     <= fetch_pkg::IDLE;
            pc_q        <= RESET_PC;
            pend_vld_q  <= 1'b0;
            pend_trap_q <= 1'b0;
            line_q      <= '0;
        end else begin
            case (state_q)
                fetch_pkg::IDLE: begin
                    if (redir_now) pc_q <= next_pc; // retarget before the bus opens.
                    else state_q <= fetch_pkg::BUSY;
                end
                fetch_pkg::BUSY: begin
                    if (i_line_strobe) begin
                        pend_vld_q  <= 1'b0;
                        pend_trap_q <= 1'b0;
                        if (redir_any) begin
                            pc_q    <= next_pc;     // line dropped.
                            state_q <= fetch_pkg::IDLE;
                        end else begin
                            line_q  <= i_line;
                            state_q <= fetch_pkg::DONE;
                        end
                    end else if (i_trap_redirect) begin
                        pend_vld_q  <= 1'b1;
                        pend_trap_q <= 1'b1;
                    end else if (i_dec_redirect && !pend_trap_q) begin
                        pend_vld_q  <= 1'b1;
                    end
                end
                fetch_pkg::DONE: begin
                    if (i_fetch_ready || redir_now) begin
                        pc_q    <= next_pc;
                        state_q <= fetch_pkg::IDLE;
                    end
                end
                default: state_q <= fetch_pkg::IDLE;
            endcase
        end
    end

    // pending target, same priority as the flags above.
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::BUSY && !i_line_strobe) begin
            if (i_trap_redirect) pend_pc_q <= i_trap_pc;
            else if (i_dec_redirect && !pend_trap_q) pend_pc_q <= i_dec_pc;
        end
        if (state_q == fetch_pkg::BUSY && i_line_strobe && !redir_any) fetch_pc_q <= pc_q;
    end

    assign o_req         = (state_q == fetch_pkg::IDLE) && !redir_now;
    assign o_req_adr     = {pc_q[PC_W-1:4], 4'b0000};
    assign o_pc          = pc_q;   // equals the bundle pc while valid.
    assign o_fetch_valid = (state_q == fetch_pkg::DONE);
    assign o_fetch_pc    = fetch_pc_q;
    assign o_fetch_line  = line_q;
    assign o_fetch_count = i_count;

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int              PC_W       = 64,
    parameter logic [PC_W-1:0] RESET_PC   = 'h1000,
    parameter int              HIST_IDX_W = 4
) (
    input  logic                      clk,
    input  logic                      i_arst_n,
    // wishbone classic master.
    output logic                      o_wb_cyc,
    output logic                      o_wb_stb,
    output logic [PC_W-1:0]           o_wb_adr,
    input  fetch_pkg::line_t          i_wb_dat,
    input  logic                      i_wb_ack,
    // bundle to decode.
    output logic                      o_fetch_valid,
    input  logic                      i_fetch_ready,
    output logic [PC_W-1:0]           o_fetch_pc,
    output fetch_pkg::line_t          o_fetch_line,
    output fetch_pkg::count_t         o_fetch_count,
    // redirects.
    input  logic                      i_dec_redirect,
    input  logic [PC_W-1:0]           i_dec_pc,
    input  logic                      i_trap_redirect,
    input  logic [PC_W-1:0]           i_trap_pc,
    // register file read for jalr.
    output fetch_pkg::reg_idx_t       o_jreg_addr,
    output logic                      o_jreg_en,
    input  logic [PC_W-1:0]           i_jreg_data,
    // branch resolve.
    input  logic                      i_bru_valid,
    input  logic [PC_W-1:0]           i_bru_pc,
    input  logic                      i_bru_taken
);

    logic                  req;
    logic [PC_W-1:0]       req_adr;
    logic                  line_strobe;
    fetch_pkg::line_t      line;
    logic [PC_W-1:0]       pc;
    logic                  taken;
    logic [PC_W-1:0]       target;
    fetch_pkg::count_t     count;
    logic [PC_W-1:0]       hist_pc;
    logic                  pred_taken;

    pc_ctrl #(
        .PC_W     (PC_W),
        .RESET_PC (RESET_PC)
    ) u_pc_ctrl (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_line_strobe   (line_strobe),
        .i_line          (line),
        .i_taken         (taken),
        .i_target        (target),
        .i_count         (count),
        .i_fetch_ready   (i_fetch_ready),
        .i_dec_redirect  (i_dec_redirect),
        .i_dec_pc        (i_dec_pc),
        .i_trap_redirect (i_trap_redirect),
        .i_trap_pc       (i_trap_pc),
        .o_req           (req),
        .o_req_adr       (req_adr),
        .o_pc            (pc),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_line    (o_fetch_line),
        .o_fetch_count   (o_fetch_count)
    );

    // scans the held bundle.
    predecode #(.PC_W(PC_W)) u_predecode (
        .i_pc         (pc),
        .i_line       (o_fetch_line),
        .i_pred_taken (pred_taken),
        .i_jreg_data  (i_jreg_data),
        .o_jreg_addr  (o_jreg_addr),
        .o_jreg_en    (o_jreg_en),
        .o_hist_pc    (hist_pc),
        .o_taken      (taken),
        .o_target     (target),
        .o_count      (count)
    );

    branch_hist #(
        .PC_W       (PC_W),
        .HIST_IDX_W (HIST_IDX_W)
    ) u_branch_hist (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_lookup_pc  (hist_pc),
        .i_bru_valid  (i_bru_valid),
        .i_bru_pc     (i_bru_pc),
        .i_bru_taken  (i_bru_taken),
        .o_pred_taken (pred_taken)
    );

    wb_fetch_master #(.PC_W(PC_W)) u_wb_fetch_master (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_req         (req),
        .i_req_adr     (req_adr),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_adr      (o_wb_adr),
        .o_line_strobe (line_strobe),
        .o_line        (line)
    );

endmodule

// File: verif/fetch_chk.sv
`timescale 1ns/1ps

module fetch_chk #(
    parameter int PC_W = 64
) (
    input logic                clk,
    input logic                i_arst_n,
    input logic                o_wb_cyc,
    input logic                o_wb_stb,
    input logic [PC_W-1:0]     o_wb_adr,
    input logic                i_wb_ack,
    input logic                o_fetch_valid,
    input logic                i_fetch_ready,
    input logic [PC_W-1:0]     o_fetch_pc,
    input fetch_pkg::line_t    o_fetch_line,
    input logic                i_dec_redirect,
    input logic                i_trap_redirect
);

    // ----------------------------------------
    // wishbone side
    // ----------------------------------------
    a_stb_cyc: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb_stb |-> o_wb_cyc) else $error("stb high without cyc");

    a_adr_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb_cyc && !i_wb_ack |=> o_wb_cyc && $stable(o_wb_adr))
        else $error("bus address moved before ack");

    // bundle held under back-pressure.
    a_bundle_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_fetch_valid && !i_fetch_ready && !i_dec_redirect && !i_trap_redirect
        |=> o_fetch_valid && $stable(o_fetch_pc) && $stable(o_fetch_line))
        else $error("bundle changed while stalled");

endmodule

bind fetch_top fetch_chk #(.PC_W(PC_W)) u_fetch_chk (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .o_wb_cyc        (o_wb_cyc),
    .o_wb_stb        (o_wb_stb),
    .o_wb_adr        (o_wb_adr),
    .i_wb_ack        (i_wb_ack),
    .o_fetch_valid   (o_fetch_valid),
    .i_fetch_ready   (i_fetch_ready),
    .o_fetch_pc      (o_fetch_pc),
    .o_fetch_line    (o_fetch_line),
    .i_dec_redirect  (i_dec_redirect),
    .i_trap_redirect (i_trap_redirect)
);

// File: verif/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    localparam logic [63:0] RESET_PC  = 64'h1000;
    localparam int          NTESTS    = 6;
    localparam int          WORST_CYC = 64;   // per bundle, stalls and refetch included.

    logic clk, i_arst_n, o_wb_cyc, o_wb_stb, i_wb_ack, o_fetch_valid, i_fetch_ready;
    logic i_dec_redirect, i_trap_redirect, o_jreg_en, i_bru_valid, i_bru_taken;
    logic [63:0] o_wb_adr, o_fetch_pc, i_dec_pc, i_trap_pc, i_jreg_data, i_bru_pc;
    fetch_pkg::line_t i_wb_dat, o_fetch_line, last_dat;
    fetch_pkg::count_t o_fetch_count;
    fetch_pkg::reg_idx_t o_jreg_addr;

    logic [31:0] imem [1024];
    logic [63:0] regs [32];
    fetch_pkg::ctr_t shadow [16];
    logic [63:0] exp_pc, last_adr;
    int seed = 91615;
    int errors = 0, checks = 0, accepted = 0, wait_cnt = 0;
    int mix = 0, stall_mode = 0, redir_mode = 0, bru_mode = 0;
    logic redir_ok = 1'b1, bundle_new = 1'b1, cyc_seen = 1'b0;
    logic st_vld = 1'b0, st_tk;
    logic [3:0] st_idx;
    int lens [NTESTS] = '{4, 40, 60, 40, 60, 40};
    string names [NTESTS] = '{"reset", "sequential", "jal_branch", "jalr", "redirect",
                              "backpressure"};

    fetch_top #(.PC_W(64), .RESET_PC(RESET_PC), .HIST_IDX_W(4)) u_fetch_top (.*);

    assign i_jreg_data = regs[o_jreg_addr];   // register file answers at once.

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int unsigned rnd(input int unsigned n);
        rnd = {$random(seed)} % n;
    endfunction

    // memory content, every bit of the address goes in.
    function automatic fetch_pkg::inst_t inst_at(input logic [63:0] a);
        logic [31:0] r;
        logic [2:0]  cls;
        r   = imem[a[11:2]] ^ a[31:0] ^ a[63:32];
        cls = r[9:7];
        if (mix == 0) cls = 3'd7;
        else if (mix == 2) cls = r[8] ? 3'd2 : 3'd7;
        case (cls)
            3'd0, 3'd1: inst_at = {r[31:7], 7'b1101111};
            3'd2:       inst_at = {r[31:15], 3'b000, r[11:7], 7'b1100111};
            3'd3, 3'd4: inst_at = {r[31:7], 7'b1100011};
            default:    inst_at = {r[31:7], 7'b0010011};
        endcase
    endfunction

    function automatic fetch_pkg::line_t line_at(input logic [63:0] a);
        line_at = {inst_at(a + 64'd12), inst_at(a + 64'd8), inst_at(a + 64'd4), inst_at(a)};
    endfunction

    // expected count and next pc of one bundle.
    function automatic logic [63:0] ref_next(input logic [63:0] pc, input fetch_pkg::line_t ln,
        output fetch_pkg::count_t cnt, output logic jr, output logic [4:0] rs1);
        logic [31:0] w;
        logic [63:0] spc, nxt;
        logic        first_br, hit;
        first_br = 1'b1;
        hit      = 1'b0;
        jr       = 1'b0;
        rs1      = '0;
        nxt      = {pc[63:4], 4'b0000} + 64'd16;
        cnt      = 3'(4 - int'(pc[3:2]));
        for (int s = int'(pc[3:2]); s < 4; s++) begin
            if (!hit) begin
                w   = ln[s*32 +: 32];
                spc = {pc[63:4], 4'b0000} + 64'(s * 4);
                if (w[1:0] == 2'b11 && w[6:2] == fetch_pkg::OPC_JAL) begin
                    hit = 1'b1;
                    nxt = spc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end else if (w[1:0] == 2'b11 && w[6:2] == fetch_pkg::OPC_JALR) begin
                    hit    = 1'b1;
                    jr     = 1'b1;
                    rs1    = w[19:15];
                    nxt    = regs[w[19:15]] + {{52{w[31]}}, w[31:20]};
                    nxt[0] = 1'b0;
                end else if (w[1:0] == 2'b11 && w[6:2] == fetch_pkg::OPC_BRANCH) begin
                    if (first_br && shadow[spc[5:2]][1]) begin
                        hit = 1'b1;
                        nxt = spc + {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                    end
                    first_br = 1'b0;   // later branches fall through.
                end
                if (hit) cnt = 3'(s - int'(pc[3:2]) + 1);
            end
        end
        ref_next = nxt;
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // ----------------------------------------
    // slave, stimulus, resolve
    // ----------------------------------------
    always @(negedge clk) begin
        if (i_wb_ack) begin
            i_wb_ack = 1'b0;
        end else if (o_wb_cyc) begin
            if (wait_cnt == 0) begin
                i_wb_ack = 1'b1;
                i_wb_dat = line_at(o_wb_adr);
                last_dat = i_wb_dat;
                last_adr = o_wb_adr;
                wait_cnt = int'(rnd(4));
            end else wait_cnt--;
        end
        i_fetch_ready   = (stall_mode != 0) ? (rnd(3) == 0) : 1'b1;
        i_dec_redirect  = 1'b0;
        i_trap_redirect = 1'b0;
        if (redir_mode != 0 && redir_ok && i_arst_n && rnd(6) == 0) begin
            redir_ok        = 1'b0;   // one redirect per bundle.
            i_dec_redirect  = (rnd(3) != 1);
            i_trap_redirect = !i_dec_redirect || (rnd(2) == 0);
            i_dec_pc        = 64'(rnd(32'h10000)) & 64'hfffc;
            i_trap_pc       = 64'(rnd(32'h10000)) & 64'hfffc;
        end
        i_bru_valid = (bru_mode != 0) && (rnd(3) == 0);
        i_bru_pc    = RESET_PC + 64'(rnd(16) << 2);
        i_bru_taken = (rnd(4) != 0);
    end

    // ----------------------------------------
    // compare
    // ----------------------------------------
    always @(posedge clk) begin
        fetch_pkg::count_t cnt;
        logic [63:0]       nxt;
        logic              jr;
        logic [4:0]        rs1;
        if (i_arst_n) begin
            if (o_wb_cyc && !cyc_seen) begin
                cyc_seen = 1'b1;
                check_val("o_wb_adr", 128'(RESET_PC), 128'(o_wb_adr));
            end
            if (o_fetch_valid) begin
                checks++;
                assert (!o_wb_cyc) else begin
                    $display("a bus cycle is open while a bundle waits at %0t", $time);
                    errors++;
                end
                if (bundle_new) begin
                    bundle_new = 1'b0;
                    check_val("o_fetch_pc", 128'(exp_pc), 128'(o_fetch_pc));
                    check_val("o_wb_adr", 128'({exp_pc[63:4], 4'b0000}), 128'(last_adr));
                    check_val("o_fetch_line", last_dat, o_fetch_line);
                end
                if (i_trap_redirect || i_dec_redirect) begin
                    exp_pc     = i_trap_redirect ? i_trap_pc : i_dec_pc;
                    bundle_new = 1'b1;
                    redir_ok   = 1'b1;
                end else if (i_fetch_ready) begin
                    nxt = ref_next(o_fetch_pc, o_fetch_line, cnt, jr, rs1);
                    check_val("o_fetch_count", 128'(cnt), 128'(o_fetch_count));
                    check_val("o_jreg_en", 128'(jr), 128'(o_jreg_en));
                    if (jr) begin
                        check_val("o_jreg_addr", 128'(rs1), 128'(o_jreg_addr));
                    end
                    exp_pc     = nxt;
                    bundle_new = 1'b1;
                    redir_ok   = 1'b1;
                    accepted++;
                end
            end else if (i_trap_redirect || i_dec_redirect) begin
                exp_pc = i_trap_redirect ? i_trap_pc : i_dec_pc;   // line in flight dropped.
            end
            // dut table writes one edge after the resolve is sampled.
            if (st_vld && st_tk && shadow[st_idx] != 2'b11) begin
                shadow[st_idx] = shadow[st_idx] + 2'd1;
            end
            if (st_vld && !st_tk && shadow[st_idx] != 2'b00) begin
                shadow[st_idx] = shadow[st_idx] - 2'd1;
            end
            st_vld = i_bru_valid;
            st_idx = i_bru_pc[5:2];
            st_tk  = i_bru_taken;
        end
    end

    initial begin
        #(64'(lens.sum()) * WORST_CYC * 100);
        $display("watchdog expired with %0d bundles accepted", accepted);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int start_err;
        int target;
        i_arst_n = 1'b0;
        i_wb_ack = 1'b0;
        i_wb_dat = '0;
        {i_fetch_ready, i_dec_redirect, i_trap_redirect, i_bru_valid, i_bru_taken} = '0;
        {i_dec_pc, i_trap_pc, i_bru_pc} = '0;
        exp_pc    = RESET_PC;
        start_err = 0;
        for (int i = 0; i < 1024; i++) imem[i] = $random(seed);
        for (int i = 0; i < 32; i++) regs[i] = (i == 0) ? 64'd0 : 64'(rnd(32'h100000)) & 64'hffff0;
        for (int i = 0; i < 16; i++) shadow[i] = 2'b01;
        repeat (5) @(posedge clk);
        checks++;
        assert (!o_wb_cyc && !o_wb_stb && !o_fetch_valid && !o_jreg_en) else begin
            $display("outputs are not idle during reset");
            errors++;
        end
        @(negedge clk) i_arst_n = 1'b1;
        for (int t = 0; t < NTESTS; t++) begin
            mix        = (t == 2 || t == 4 || t == 5) ? 1 : ((t == 3) ? 2 : 0);
            bru_mode   = (t == 2 || t == 5) ? 1 : 0;
            redir_mode = (t == 4) ? 1 : 0;
            stall_mode = (t == 5) ? 1 : 0;
            target     = accepted + lens[t];
            wait (accepted >= target);
            $display("test %0d %s finished with %0d errors", t + 1, names[t], errors - start_err);
            start_err  = errors;
        end
        $display("%0d checks, %0d errors, %0d bundles", checks, errors, accepted);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
common/fetch_pkg.sv
rtl/predecode.sv
rtl/branch_hist.sv
rtl/wb_fetch_master.sv
pc_ctrl/pc_ctrl.sv
rtl/fetch_top.sv
verif/fetch_chk.sv
verif/tb_fetch.sv

// File: Makefile
TOP = tb_fetch

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^TEST PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: sim clean
